//--- hdl/hyper_read_pkg.sv
// Shared types for the HyperBus read data path
// DDR byte, assembled word, burst length, output beat and tracker states

package hyper_read_pkg;

    // Bus and word widths
    localparam int unsigned BYTE_W = 8;
    localparam int unsigned WORD_W = 2 * BYTE_W;
    // Burst length counter width, bursts of 1 to 255 words
    localparam int unsigned BURST_LEN_W = 8;

    // One byte on hyper_dq, half of a DDR cycle
    typedef logic [BYTE_W-1:0] byte_t;

    // One assembled read word
    // Upper half is the byte from the rising edge, lower half from the falling edge
    typedef logic [WORD_W-1:0] word_t;

    // Burst length in words, zero is not a legal request
    typedef logic [BURST_LEN_W-1:0] burst_len_t;

    // Beat handed to the controller
    typedef struct packed {
        word_t data;
        logic  last;
    } rd_beat_t;

    // Burst tracker states
    // IDLE waits for a request, BURST pops words until the count is reached
    typedef enum logic {
        IDLE  = 1'b0,
        BURST = 1'b1
    } track_state_e;

endpackage

//--- hdl/ddr_word_capture.sv
// DDR input capture for the HyperBus read path
// Rising and falling byte of each clk_rwds cycle are joined into one word

module ddr_word_capture (
    input  logic                  clk_rwds,
    input  logic                  rst_ni,
    input  hyper_read_pkg::byte_t hyper_dq_i,
    input  logic                  capture_en_i,
    output logic                  word_valid_o,
    output hyper_read_pkg::word_t word_o
);

    // Byte sampled on the rising edge, later the upper half
    hyper_read_pkg::byte_t upper_q;
    // Byte sampled on the following falling edge, later the lower half
    hyper_read_pkg::byte_t lower_q;
    // Capture window as seen at the rising edge of the byte pair
    logic                  en_q;

    // Rising edge sampler for the upper byte
    // Clock is the delayed strobe so data sits centred on this edge
    always_ff @(posedge clk_rwds) begin
        upper_q <= hyper_dq_i;
    end

    // Falling edge sampler for the lower byte
    always_ff @(negedge clk_rwds) begin
        lower_q <= hyper_dq_i;
    end

    // Remember whether this byte pair lies inside the read window
    always_ff @(posedge clk_rwds or negedge rst_ni) begin
        if (!rst_ni) begin
            en_q <= 1'b0;
        end else begin
            en_q <= capture_en_i;
        end
    end

    // Strobe for the assembled word, one cycle after the rising byte
    // Drops on the edge after capture_en_i went low
    always_ff @(posedge clk_rwds or negedge rst_ni) begin
        if (!rst_ni) begin
            word_valid_o <= 1'b0;
        end else begin
            word_valid_o <= en_q;
        end
    end

    // Word register
    // upper_q still holds the byte of edge N here since it updates on the same edge
    always_ff @(posedge clk_rwds) begin
        word_o <= {upper_q, lower_q};
    end

endmodule

//--- hdl/read_word_fifo.sv
// Single-clock FIFO buffering captured read words
// Sticky overflow flag on writes that hit a full FIFO, cleared by flush

module read_word_fifo #(
    parameter int unsigned LOG_DEPTH = 4
) (
    input  logic                  clk_rwds,
    input  logic                  rst_ni,
    input  logic                  flush_i,
    input  logic                  push_i,
    input  hyper_read_pkg::word_t push_word_i,
    input  logic                  pop_i,
    output logic                  empty_o,
    output hyper_read_pkg::word_t head_word_o,
    output logic                  overflow_o
);

    localparam int unsigned DEPTH = 2 ** LOG_DEPTH;

    // Storage, no reset needed since the pointers define what is valid
    hyper_read_pkg::word_t mem_q [DEPTH];

    // Pointers carry one extra wrap bit
    logic [LOG_DEPTH:0] wr_ptr_q;
    logic [LOG_DEPTH:0] rd_ptr_q;

    logic full;
    logic do_push;
    logic do_pop;

    // Same address and same wrap bit means nothing stored
    assign empty_o = (wr_ptr_q == rd_ptr_q);
    // Same address, different wrap bit means every slot taken
    assign full    = (wr_ptr_q[LOG_DEPTH] != rd_ptr_q[LOG_DEPTH]) &&
                     (wr_ptr_q[LOG_DEPTH-1:0] == rd_ptr_q[LOG_DEPTH-1:0]);

    // A full FIFO drops the incoming word
    assign do_push = push_i && !full && !flush_i;
    assign do_pop  = pop_i && !empty_o && !flush_i;

    // Head is shown without a register stage
    assign head_word_o = mem_q[rd_ptr_q[LOG_DEPTH-1:0]];

    // Pointer update, flush wins over push and pop
    always_ff @(posedge clk_rwds or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
        end else if (flush_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
        end
    end

    // Word write into the slot at the write address
    always_ff @(posedge clk_rwds) begin
        if (do_push) begin
            mem_q[wr_ptr_q[LOG_DEPTH-1:0]] <= push_word_i;
        end
    end

    // Overflow stays set until reset or flush
    // Capture has no ready, so a lost word must be visible to the controller
    always_ff @(posedge clk_rwds or negedge rst_ni) begin
        if (!rst_ni) begin
            overflow_o <= 1'b0;
        end else if (flush_i) begin
            overflow_o <= 1'b0;
        end else if (push_i && full) begin
            overflow_o <= 1'b1;
        end
    end

endmodule

//--- hdl/read_burst_tracker.sv
// Burst tracker for the HyperBus read path
// Takes a burst request, pops FIFO words under back-pressure, marks the last beat

module read_burst_tracker (
    input  logic                       clk_rwds,
    input  logic                       rst_ni,
    input  logic                       read_req_i,
    input  hyper_read_pkg::burst_len_t burst_len_i,
    input  logic                       fifo_empty_i,
    input  hyper_read_pkg::word_t      fifo_word_i,
    input  logic                       ready_i,
    output logic                       fifo_pop_o,
    output logic                       rd_valid_o,
    output hyper_read_pkg::rd_beat_t   rd_beat_o,
    output logic                       busy_o
);

    hyper_read_pkg::track_state_e state_q;
    hyper_read_pkg::track_state_e state_d;

    // Requested length and beats already handed out
    hyper_read_pkg::burst_len_t len_q;
    hyper_read_pkg::burst_len_t beat_cnt_q;
    hyper_read_pkg::burst_len_t beat_cnt_nxt;

    logic beat_fire;
    logic last_beat;

    assign busy_o = (state_q == hyper_read_pkg::BURST);

    // A beat is offered whenever a word waits during a burst
    assign rd_valid_o = busy_o && !fifo_empty_i;
    // Transfer when the controller takes it
    assign beat_fire  = rd_valid_o && ready_i;
    // Only pops a non-empty FIFO since rd_valid_o already checks that
    assign fifo_pop_o = beat_fire;

    // Count after this beat, cannot wrap since len_q is at most 255
    assign beat_cnt_nxt = beat_cnt_q + 8'd1;
    assign last_beat    = (beat_cnt_nxt == len_q);

    // FIFO head goes out only while a burst runs
    // Held stable under back-pressure because nothing pops
    always_comb begin
        rd_beat_o.data = busy_o ? fifo_word_i : '0;
        rd_beat_o.last = busy_o && last_beat;
    end

    // Next state
    always_comb begin
        state_d = state_q;
        unique case (state_q)
            hyper_read_pkg::IDLE: begin
                // Requests are ignored while a burst runs
                if (read_req_i) begin
                    state_d = hyper_read_pkg::BURST;
                end
            end
            hyper_read_pkg::BURST: begin
                // Back to IDLE on the edge of the final accepted beat
                if (beat_fire && last_beat) begin
                    state_d = hyper_read_pkg::IDLE;
                end
            end
            default: begin
                state_d = hyper_read_pkg::IDLE;
            end
        endcase
    end

    // State, length and beat counter
    always_ff @(posedge clk_rwds or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q    <= hyper_read_pkg::IDLE;
            len_q      <= '0;
            beat_cnt_q <= '0;
        end else begin
            state_q <= state_d;
            if (state_q == hyper_read_pkg::IDLE && read_req_i) begin
                // Load a fresh burst
                len_q      <= burst_len_i;
                beat_cnt_q <= '0;
            end else if (beat_fire) begin
                beat_cnt_q <= beat_cnt_nxt;
            end
        end
    end

endmodule

//--- hdl/hyper_read_top.sv
// Top of the HyperBus read data path
// DDR capture into a word FIFO, drained by the burst tracker

module hyper_read_top #(
    parameter int unsigned LOG_DEPTH = 4
) (
    input  logic                       clk_rwds,
    input  logic                       rst_ni,
    input  hyper_read_pkg::byte_t      hyper_dq_i,
    input  logic                       capture_en_i,
    input  logic                       fifo_flush_i,
    input  logic                       read_req_i,
    input  hyper_read_pkg::burst_len_t burst_len_i,
    input  logic                       ready_i,
    output logic                       rd_valid_o,
    output hyper_read_pkg::rd_beat_t   rd_beat_o,
    output logic                       busy_o,
    output logic                       overflow_o
);

    // Capture to FIFO, plain strobe without ready
    logic                  word_valid;
    hyper_read_pkg::word_t word;

    // FIFO to tracker
    logic                  fifo_empty;
    hyper_read_pkg::word_t fifo_word;
    logic                  fifo_pop;

    // Byte pairs from the bus into words
    ddr_word_capture i_ddr_word_capture (
        .clk_rwds     ( clk_rwds     ),
        .rst_ni       ( rst_ni       ),
        .hyper_dq_i   ( hyper_dq_i   ),
        .capture_en_i ( capture_en_i ),
        .word_valid_o ( word_valid   ),
        .word_o       ( word         )
    );

    // Buffer for words waiting on back-pressure
    read_word_fifo #(
        .LOG_DEPTH ( LOG_DEPTH )
    ) i_read_word_fifo (
        .clk_rwds    ( clk_rwds     ),
        .rst_ni      ( rst_ni       ),
        .flush_i     ( fifo_flush_i ),
        .push_i      ( word_valid   ),
        .push_word_i ( word         ),
        .pop_i       ( fifo_pop     ),
        .empty_o     ( fifo_empty   ),
        .head_word_o ( fifo_word    ),
        .overflow_o  ( overflow_o   )
    );

    // Burst length and last marker towards the controller
    read_burst_tracker i_read_burst_tracker (
        .clk_rwds     ( clk_rwds    ),
        .rst_ni       ( rst_ni      ),
        .read_req_i   ( read_req_i  ),
        .burst_len_i  ( burst_len_i ),
        .fifo_empty_i ( fifo_empty  ),
        .fifo_word_i  ( fifo_word   ),
        .ready_i      ( ready_i     ),
        .fifo_pop_o   ( fifo_pop    ),
        .rd_valid_o   ( rd_valid_o  ),
        .rd_beat_o    ( rd_beat_o   ),
        .busy_o       ( busy_o      )
    );

endmodule

//--- tests/tb_hyper_read.sv
// Testbench for the HyperBus read data path
// Reads cases from tests/hyper_read_cases.txt, drives DDR bytes and ready_i, checks the beats
// In waves, UUT.i_read_burst_tracker.state_q shows track_state_e IDLE or BURST

module tb_hyper_read;

    localparam int TIMEOUT_CYCLES = 400;
    localparam int FIFO_DEPTH     = 16;

    logic                       clk_rwds = 1'b0;
    logic                       rst_ni;
    hyper_read_pkg::byte_t      hyper_dq_i;
    logic                       capture_en_i;
    logic                       fifo_flush_i;
    logic                       read_req_i;
    hyper_read_pkg::burst_len_t burst_len_i;
    logic                       ready_i;
    logic                       rd_valid_o;
    hyper_read_pkg::rd_beat_t   rd_beat_o;
    logic                       busy_o;
    logic                       overflow_o;

    // Stale words go in before the flush and fresh words after it
    hyper_read_pkg::word_t stale_q[$];
    hyper_read_pkg::word_t fresh_q[$];
    // Beats still owed by the DUT
    hyper_read_pkg::word_t exp_q[$];

    int errors       = 0;
    int tests_run    = 0;
    int tests_failed = 0;

    hyper_read_top #(
        .LOG_DEPTH ( 4 )
    ) UUT (
        .clk_rwds     ( clk_rwds     ),
        .rst_ni       ( rst_ni       ),
        .hyper_dq_i   ( hyper_dq_i   ),
        .capture_en_i ( capture_en_i ),
        .fifo_flush_i ( fifo_flush_i ),
        .read_req_i   ( read_req_i   ),
        .burst_len_i  ( burst_len_i  ),
        .ready_i      ( ready_i      ),
        .rd_valid_o   ( rd_valid_o   ),
        .rd_beat_o    ( rd_beat_o    ),
        .busy_o       ( busy_o       ),
        .overflow_o   ( overflow_o   )
    );

    always #2 clk_rwds = ~clk_rwds;

    // One word per cycle with the upper byte ahead of the rising edge
    // Lower byte goes out ahead of the falling edge
    // Bytes move 1 unit after each edge like a strobe delayed by a quarter period
    task automatic capture_words(input bit use_stale);
        hyper_read_pkg::word_t w;
        int n;
        n = use_stale ? stale_q.size() : fresh_q.size();
        for (int i = 0; i < n; i++) begin
            w = use_stale ? stale_q[i] : fresh_q[i];
            @(negedge clk_rwds);
            capture_en_i = 1'b1;
            #1;
            hyper_dq_i = w[15:8];
            @(posedge clk_rwds);
            #1;
            hyper_dq_i = w[7:0];
        end
        @(negedge clk_rwds);
        capture_en_i = 1'b0;
        #1;
        hyper_dq_i = '0;
    endtask

    // Controller back-pressure for one cycle
    function automatic logic ready_value(input string rmode, input int rarg, input int cycle);
        logic value;
        if (rmode == "random") begin
            value = ($urandom % 2) == 0;
        end else if (rmode == "hold") begin
            value = (cycle >= rarg);
        end else begin
            value = 1'b1;
        end
        return value;
    endfunction

    task automatic run_case(input string mode, input int blen, input string rmode, input int rarg);
        int errs_before;
        int got;
        int cycle;
        logic held;
        hyper_read_pkg::rd_beat_t held_beat;
        hyper_read_pkg::word_t exp_word;
        string status;

        errs_before = errors;
        tests_run++;
        got = 0;
        exp_q.delete();
        for (int i = 0; i < blen; i++) begin
            exp_q.push_back(fresh_q[i]);
        end

        // Fill with words that the flush must discard
        if (stale_q.size() > 0) begin
            // Ready high so a beat offered by the idle tracker would be taken
            ready_i = 1'b1;
            capture_words(1'b1);
            // Last word needs two more edges to land in the FIFO
            // Idle tracker offers none of the words waiting there
            for (int k = 0; k < 3; k++) begin
                @(negedge clk_rwds);
                if (rd_valid_o !== 1'b0) begin
                    $display("Error at %0t: rd_valid_o expected 0 got %b", $time, rd_valid_o);
                    errors++;
                end
            end
            if (stale_q.size() > FIFO_DEPTH && overflow_o !== 1'b1) begin
                $display("Error at %0t: overflow_o expected 1 got %b", $time, overflow_o);
                errors++;
            end
            fifo_flush_i = 1'b1;
            @(negedge clk_rwds);
            fifo_flush_i = 1'b0;
            if (overflow_o !== 1'b0) begin
                $display("Error at %0t: overflow_o expected 0 got %b", $time, overflow_o);
                errors++;
            end
        end

        @(negedge clk_rwds);
        read_req_i  = 1'b1;
        burst_len_i = hyper_read_pkg::burst_len_t'(blen);
        @(negedge clk_rwds);
        read_req_i = 1'b0;
        if (busy_o !== 1'b1) begin
            $display("Error at %0t: busy_o expected 1 got %b", $time, busy_o);
            errors++;
        end

        fork
            capture_words(1'b0);
            begin
                cycle     = 0;
                held      = 1'b0;
                held_beat = '0;
                while (got < blen && cycle < TIMEOUT_CYCLES) begin
                    @(negedge clk_rwds);
                    ready_i = ready_value(rmode, rarg, cycle);
                    #1;
                    // A refused beat stays on the bus unchanged
                    if (held && rd_valid_o !== 1'b1) begin
                        $display("Error at %0t: rd_valid_o expected 1 got %b", $time, rd_valid_o);
                        errors++;
                    end
                    if (held && rd_beat_o !== held_beat) begin
                        $display("Error at %0t: rd_beat_o expected %h got %h",
                                 $time, held_beat, rd_beat_o);
                        errors++;
                    end
                    if (rd_valid_o === 1'b1 && ready_i === 1'b1) begin
                        got++;
                        exp_word = exp_q.pop_front();
                        if (rd_beat_o.data !== exp_word) begin
                            $display("Error at %0t: rd_beat_o.data expected %h got %h",
                                     $time, exp_word, rd_beat_o.data);
                            errors++;
                        end
                        if (rd_beat_o.last !== (got == blen)) begin
                            $display("Error at %0t: rd_beat_o.last expected %b got %b",
                                     $time, got == blen, rd_beat_o.last);
                            errors++;
                        end
                    end
                    held      = rd_valid_o && !ready_i;
                    held_beat = rd_beat_o;
                    cycle++;
                end
                if (got < blen) begin
                    $display("Timeout at %0t: only %0d of %0d beats arrived in %0d cycles",
                             $time, got, blen, TIMEOUT_CYCLES);
                    errors++;
                end
            end
        join

        // Final beat leaves on the edge after its sample
        @(negedge clk_rwds);
        if (got == blen && busy_o !== 1'b0) begin
            $display("Error at %0t: busy_o expected 0 got %b", $time, busy_o);
            errors++;
        end
        ready_i = 1'b1;
        // Tracker is idle so nothing may be offered
        for (int k = 0; k < 4; k++) begin
            @(negedge clk_rwds);
            if (rd_valid_o !== 1'b0) begin
                $display("Error at %0t: rd_valid_o expected 0 got %b", $time, rd_valid_o);
                errors++;
            end
        end
        if (overflow_o !== (mode == "overflow")) begin
            $display("Error at %0t: overflow_o expected %b got %b",
                     $time, mode == "overflow", overflow_o);
            errors++;
        end

        status = "passed";
        if (errors != errs_before) begin
            tests_failed++;
            status = "failed";
        end
        $display("Test %0d: %s, burst %0d, ready %s, %0d beats, %s",
                 tests_run, mode, blen, rmode, got, status);
    endtask

    initial begin
        int fd;
        int code;
        int ch;
        int blen;
        int rarg;
        int nstale;
        int nfresh;
        bit ok;
        string tok;
        string mode;
        string rmode;
        hyper_read_pkg::word_t w;

        void'($urandom(1));
        rst_ni       = 1'b0;
        hyper_dq_i   = '0;
        capture_en_i = 1'b0;
        fifo_flush_i = 1'b0;
        read_req_i   = 1'b0;
        burst_len_i  = '0;
        ready_i      = 1'b0;
        repeat (3) @(negedge clk_rwds);
        rst_ni = 1'b1;

        // Quiet outputs out of reset
        @(negedge clk_rwds);
        if (rd_valid_o !== 1'b0 || busy_o !== 1'b0 || overflow_o !== 1'b0) begin
            $display("Error at %0t: rd_valid_o busy_o overflow_o expected 000 got %b%b%b",
                     $time, rd_valid_o, busy_o, overflow_o);
            errors++;
        end

        fd = $fopen("tests/hyper_read_cases.txt", "r");
        if (fd == 0) begin
            $display("The cases file tests/hyper_read_cases.txt could not be opened");
            errors++;
        end else begin
            while ($fscanf(fd, "%s", tok) == 1) begin
                if (tok == "#") begin
                    ch = $fgetc(fd);
                    while (ch != 10 && ch != -1) begin
                        ch = $fgetc(fd);
                    end
                end else begin
                    mode = tok;
                    code = $fscanf(fd, "%d %s %d %d %d", blen, rmode, rarg, nstale, nfresh);
                    ok = (code == 5);
                    stale_q.delete();
                    fresh_q.delete();
                    for (int i = 0; ok && i < nstale + nfresh; i++) begin
                        if ($fscanf(fd, "%h", w) != 1) begin
                            ok = 1'b0;
                        end else if (i < nstale) begin
                            stale_q.push_back(w);
                        end else begin
                            fresh_q.push_back(w);
                        end
                    end
                    if (!ok) begin
                        $display("A case in the cases file is incomplete, reading stopped");
                        errors++;
                        break;
                    end
                    if (!(mode == "normal" || mode == "stall" || mode == "overflow" ||
                          mode == "flush") || !(rmode == "always" || rmode == "random" ||
                          rmode == "hold") || blen < 1 || blen > 255 || nfresh < blen) begin
                        $display("Case with mode %s and ready %s is not valid, skipped",
                                 mode, rmode);
                        errors++;
                    end else begin
                        run_case(mode, blen, rmode, rarg);
                    end
                end
            end
            $fclose(fd);
        end

        if (tests_run == 0) begin
            $display("No test case was run");
            errors++;
        end
        $display("Summary: %0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

//--- tests/hyper_read_cases.txt
# Columns: mode burst_len ready ready_arg stale_words fresh_words, then all words in hex
# ready is always, random or hold (low for ready_arg cycles); stale words are flushed first

# Ready always high
normal    1 always  0  0  1  a55a
normal    2 always  0  0  2  0102 0304
normal    3 always  0  0  3  ffff 0000 8001
normal    4 always  0  0  4  1234 5678 9abc def0
normal    8 always  0  0  8  0011 2233 4455 6677 8899 aabb ccdd eeff
normal   12 always  0  0 12  a001 a002 a003 a004 a005 a006 a007 a008 a009 a00a a00b a00c
normal   16 always  0  0 16  c000 c001 c002 c003 c004 c005 c006 c007
                             c008 c009 c00a c00b c00c c00d c00e c00f

# Random back-pressure
normal    5 random  0  0  5  5a01 5a02 5a03 5a04 5a05
normal    9 random  0  0  9  f00f 0ff0 aa55 55aa 1357 2468 9bdf ace0 7e7e
normal   16 random  0  0 16  0001 0002 0004 0008 0010 0020 0040 0080
                             0100 0200 0400 0800 1000 2000 4000 8000
stall     7 random  0  0  7  3c3c c3c3 0f0f f0f0 a0a0 0a0a 5050
stall     3 random  0  0  3  0ace 1bdf 2ce0

# Ready held low while capture runs
stall     1 hold    6  0  1  7fff
stall     4 hold    3  0  4  dead beef cafe f00d
stall     8 hold   12  0  8  1001 2002 3003 4004 5005 6006 7007 8008
stall    16 hold   24  0 16  e000 e001 e002 e003 e004 e005 e006 e007
                             e008 e009 e00a e00b e00c e00d e00e e00f

# More words than the FIFO holds, only the first 16 come out
overflow 16 hold   30  0 17  b000 b001 b002 b003 b004 b005 b006 b007
                             b008 b009 b00a b00b b00c b00d b00e b00f b010
overflow 16 hold   40  0 24  d000 d001 d002 d003 d004 d005 d006 d007 d008 d009 d00a d00b
                             d00c d00d d00e d00f d010 d011 d012 d013 d014 d015 d016 d017

# Stale words before a flush must never appear
flush     4 always  0  6  4  6611 6622 6633 6644 6655 6666 4401 4402 4403 4404
flush     3 random  0 18  3  9900 9901 9902 9903 9904 9905 9906 9907 9908 9909
                             990a 990b 990c 990d 990e 990f 9910 9911 3301 3302 3303
flush     5 hold    4  2  5  7711 7722 5501 5502 5503 5504 5505

# Normal traffic after the flushes
normal    6 always  0  0  6  0a0b 0c0d 0e0f 1a1b 1c1d 1e1f
stall     6 hold    2  0  6  2101 2102 2103 2104 2105 2106

//--- filelist.f
hdl/hyper_read_pkg.sv
hdl/ddr_word_capture.sv
hdl/read_word_fifo.sv
hdl/read_burst_tracker.sv
hdl/hyper_read_top.sv
tests/tb_hyper_read.sv

//--- Makefile
# Verilator build and run of the HyperBus read data path testbench

VERILATOR := verilator
VFLAGS    := --binary --timing
TOP       := tb_hyper_read
FILELIST  := filelist.f
BUILD_DIR := obj_dir
PASS_MSG  := NO ERRORS

SOURCES := $(filter %.sv %.v,$(shell cat $(FILELIST)))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# Output is shown and searched for the pass message, which sets the status
run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '$(PASS_MSG)'

clean:
	rm -rf $(BUILD_DIR)
